/* source/can_rx_macros.svh */
`ifndef CAN_RX_MACROS_SVH
`define CAN_RX_MACROS_SVH

// ==============================
// Frame field lengths
// ==============================
`define CAN_ID_A_BITS          11  // Base identifier
`define CAN_ID_B_BITS          18  // Identifier extension
`define CAN_DLC_BITS           4
`define CAN_MAX_DATA_BYTES     8   // DLC 9..15 clamps here
`define CAN_DATA_BITS          64  // 8 bytes max
`define CAN_CRC_BITS           15
`define CAN_CRC_POLY           15'h4599  // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1

// ==============================
// Bit-level timing of the frame tail
// ==============================
`define CAN_STUFF_RUN          5   // Equal bits before a stuff bit
`define CAN_EOF_BITS           7
`define CAN_INTERMISSION_BITS  3   // Dominant on last bit means SOF
`define CAN_RECOVERY_BITS      8   // Recessive run to leave recovery

`endif

/* source/can_rx_pkg.sv */
`default_nettype none

package can_rx_pkg;

	// Decoder state, one per frame field
	// Order matters, range checks use id_a..data and id_a..crc_delim
	typedef enum logic [4:0] {
		st_idle,          // Bus idle, waiting for SOF
		st_id_a,          // 11 bit base id
		st_rtr_srr,       // RTR in base frame, SRR in extended
		st_ide,
		st_id_b,          // 18 bit extension
		st_rtr,           // Extended frame RTR
		st_reserved1,
		st_reserved0,
		st_dlc,
		st_data,
		st_crc,
		st_crc_delim,     // Last bit that may be a stuff bit
		st_ack_slot,
		st_ack_delim,
		st_eof,
		st_intermission,
		st_recovery       // After any error
	} can_state_e;

	// Reported with the frame_error pulse
	typedef enum logic [2:0] {
		err_none,
		err_stuff,        // Sixth equal bit
		err_form,         // Fixed-form field violated
		err_crc,          // Mismatch seen at ACK delimiter
		err_ack           // No dominant ACK slot
	} can_error_e;

endpackage

`default_nettype wire

/* source/can_bit_destuffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "can_rx_macros.svh"

module can_bit_destuffer (
	input  wire  clock,
	input  wire  reset,
	input  wire  rx_bit,
	input  wire  sample_point,
	input  wire  stuff_region,   // From decoder, id_a..crc_delim
	output logic stuff_bit,      // Drop this bit
	output logic stuff_error     // Sixth equal bit
);

	// ==============================
	// Bit history
	// ==============================

	// Alternating preset so no run exists after reset
	localparam logic [2*`CAN_STUFF_RUN-1:0] alt_pattern = {`CAN_STUFF_RUN{2'b10}};

	logic [`CAN_STUFF_RUN-1:0] history;  // Newest bit in LSB
	logic run_low;                       // Last five dominant
	logic run_high;                      // Last five recessive

	// Every sampled bit goes in, stuff bits included
	// A stuff bit starts the next run in CAN
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			history <= alt_pattern[`CAN_STUFF_RUN-1:0];
		end
		else if (sample_point)
		begin
			history <= {history[`CAN_STUFF_RUN-2:0], rx_bit};
		end
	end

	// ==============================
	// Stuff decision
	// ==============================

	assign run_low  = (history == '0);
	assign run_high = &history;

	// Opposite polarity after a run is the inserted bit
	assign stuff_bit = sample_point & stuff_region &
		((run_low & rx_bit) | (run_high & ~rx_bit));

	// Same polarity again breaks the stuffing rule
	assign stuff_error = sample_point & stuff_region &
		((run_low & ~rx_bit) | (run_high & rx_bit));

endmodule

`default_nettype wire

/* source/can_crc_check.sv */
`timescale 1ns/1ns
`default_nettype none

`include "can_rx_macros.svh"

module can_crc_check
	import can_rx_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        rx_bit,
	input  wire        bit_take,     // Sample without stuff bit
	input  can_state_e state,
	input  wire        frame_start,
	output logic       crc_match     // Level, read at ACK delimiter
);

	localparam logic [`CAN_CRC_BITS-1:0] crc_poly = `CAN_CRC_POLY;

	logic [`CAN_CRC_BITS-1:0] crc_calc;   // Running LFSR
	logic [`CAN_CRC_BITS-1:0] crc_rx;     // CRC field as received
	logic feedback;

	assign feedback = rx_bit ^ crc_calc[`CAN_CRC_BITS-1];

	// SOF is dominant, so skipping it leaves a zero LFSR unchanged
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			crc_calc <= '0;
			crc_rx   <= '0;
		end
		else if (frame_start)
		begin
			crc_calc <= '0;
			crc_rx   <= '0;
		end
		else if (bit_take && (state inside {[st_id_a:st_data]}))
		begin
			crc_calc <= {crc_calc[`CAN_CRC_BITS-2:0], 1'b0} ^ (crc_poly & {`CAN_CRC_BITS{feedback}});
		end
		else if (bit_take && (state == st_crc))
		begin
			crc_rx <= {crc_rx[`CAN_CRC_BITS-2:0], rx_bit};  // MSB first
		end
	end

	assign crc_match = (crc_calc == crc_rx);

endmodule

`default_nettype wire

/* source/can_frame_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "can_rx_macros.svh"

module can_frame_decoder
	import can_rx_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        rx_bit,
	input  wire        sample_point,
	input  wire        stuff_bit,
	input  wire        stuff_error,
	input  wire        crc_match,
	output logic       stuff_region,
	output logic       bit_take,
	output logic       frame_start,
	output can_state_e state,
	output logic       ide,
	output logic       rtr,
	output logic [`CAN_DLC_BITS-1:0] dlc,
	output logic       frame_valid,
	output logic       frame_error,
	output can_error_e error_kind
);

	// ==============================
	// Field lengths as counter values
	// ==============================
	localparam int cnt_w = $clog2(`CAN_DATA_BITS);  // Data is the longest field
	localparam logic [cnt_w-1:0] id_a_last     = `CAN_ID_A_BITS - 1;
	localparam logic [cnt_w-1:0] id_b_last     = `CAN_ID_B_BITS - 1;
	localparam logic [cnt_w-1:0] dlc_last      = `CAN_DLC_BITS - 1;
	localparam logic [cnt_w-1:0] crc_last      = `CAN_CRC_BITS - 1;
	localparam logic [cnt_w-1:0] eof_last      = `CAN_EOF_BITS - 1;
	localparam logic [cnt_w-1:0] inter_last    = `CAN_INTERMISSION_BITS - 1;
	localparam logic [cnt_w-1:0] recovery_last = `CAN_RECOVERY_BITS - 1;
	localparam logic [`CAN_DLC_BITS-1:0] dlc_max = `CAN_MAX_DATA_BYTES;

	logic [cnt_w-1:0] bit_cnt;              // Shared by all multi-bit fields
	logic rtr_srr;                          // Held until IDE says which it is
	logic [`CAN_DLC_BITS-1:0] dlc_next;
	logic data_end;                         // Last bit of last byte
	can_error_e err;                        // Error seen in this sample

	assign stuff_region = (state inside {[st_id_a:st_crc_delim]});
	assign bit_take     = sample_point & ~stuff_bit;
	assign dlc_next     = {dlc[`CAN_DLC_BITS-2:0], rx_bit};
	assign data_end     = ({1'b0, bit_cnt} == ({dlc, 3'b000} - 7'd1));  // 8 bits per byte

	// SOF from idle, or dominant on the last intermission bit
	assign frame_start = sample_point & ~rx_bit &
		((state == st_idle) | ((state == st_intermission) & (bit_cnt == inter_last)));

	// ==============================
	// Error detection
	// ==============================
	always_comb
	begin
		err = err_none;
		if (sample_point)
		begin
			if (stuff_error)
				err = err_stuff;
			else if (!stuff_bit)
			begin
				case (state)
					st_ide:          if (rx_bit && !rtr_srr) err = err_form;  // SRR dominant
					st_crc_delim:    if (!rx_bit) err = err_form;
					st_ack_slot:     if (rx_bit) err = err_ack;                // Nobody acked
					st_ack_delim:
					begin
						if (!crc_match)
							err = err_crc;     // CRC wins over delimiter
						else if (!rx_bit)
							err = err_form;
					end
					st_eof:          if (!rx_bit) err = err_form;
					st_intermission: if (!rx_bit && (bit_cnt != inter_last)) err = err_form;
					default:         err = err_none;
				endcase
			end
		end
	end

	// ==============================
	// Frame state machine
	// ==============================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= st_idle;
			bit_cnt     <= '0;
			rtr_srr     <= 1'b0;
			ide         <= 1'b0;
			rtr         <= 1'b0;
			dlc         <= '0;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			error_kind  <= err_none;
		end
		else
		begin
			// Pulses last one clock
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			error_kind  <= err_none;

			if (err != err_none)
			begin
				frame_error <= 1'b1;
				error_kind  <= err;
				state       <= st_recovery;
				bit_cnt     <= '0;
			end
			else if (frame_start)
			begin
				state   <= st_id_a;
				bit_cnt <= '0;
				ide     <= 1'b0;
				rtr     <= 1'b0;
				dlc     <= '0;
			end
			else if (bit_take)
			begin
				case (state)
					st_id_a:
					begin
						bit_cnt <= (bit_cnt == id_a_last) ? '0 : bit_cnt + 1'b1;
						if (bit_cnt == id_a_last)
							state <= st_rtr_srr;
					end
					st_rtr_srr:
					begin
						rtr_srr <= rx_bit;
						state   <= st_ide;
					end
					st_ide:
					begin
						ide <= rx_bit;
						if (rx_bit)
							state <= st_id_b;  // Extended, SRR already checked
						else
						begin
							rtr   <= rtr_srr;  // Base frame RTR
							state <= st_reserved0;
						end
					end
					st_id_b:
					begin
						bit_cnt <= (bit_cnt == id_b_last) ? '0 : bit_cnt + 1'b1;
						if (bit_cnt == id_b_last)
							state <= st_rtr;
					end
					st_rtr:
					begin
						rtr   <= rx_bit;
						state <= st_reserved1;
					end
					st_reserved1: state <= st_reserved0;
					st_reserved0: state <= st_dlc;
					st_dlc:
					begin
						if (bit_cnt == dlc_last)
						begin
							dlc     <= dlc_next[`CAN_DLC_BITS-1] ? dlc_max : dlc_next;  // 9..15 -> 8
							bit_cnt <= '0;
							state   <= ((dlc_next == '0) || rtr) ? st_crc : st_data;
						end
						else
						begin
							dlc     <= dlc_next;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					st_data:
					begin
						bit_cnt <= data_end ? '0 : bit_cnt + 1'b1;
						if (data_end)
							state <= st_crc;
					end
					st_crc:
					begin
						bit_cnt <= (bit_cnt == crc_last) ? '0 : bit_cnt + 1'b1;
						if (bit_cnt == crc_last)
							state <= st_crc_delim;
					end
					st_crc_delim: state <= st_ack_slot;
					st_ack_slot:  state <= st_ack_delim;
					st_ack_delim:
					begin
						state   <= st_eof;
						bit_cnt <= '0;
					end
					st_eof:
					begin
						bit_cnt <= (bit_cnt == eof_last) ? '0 : bit_cnt + 1'b1;
						if (bit_cnt == eof_last)
						begin
							frame_valid <= 1'b1;  // Fields stay put until next SOF
							state       <= st_intermission;
						end
					end
					st_intermission:
					begin
						bit_cnt <= (bit_cnt == inter_last) ? '0 : bit_cnt + 1'b1;
						if (bit_cnt == inter_last)
							state <= st_idle;
					end
					st_recovery:
					begin
						if (!rx_bit)
							bit_cnt <= '0;      // Dominant restarts the count
						else if (bit_cnt == recovery_last)
						begin
							bit_cnt <= '0;
							state   <= st_idle;
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					st_idle: state <= st_idle;  // Recessive bus
					default: state <= st_idle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/can_field_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "can_rx_macros.svh"

module can_field_capture
	import can_rx_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        rx_bit,
	input  wire        bit_take,     // Destuffed sample
	input  can_state_e state,
	input  wire        frame_start,  // Clears all fields
	output logic [`CAN_ID_A_BITS-1:0] id_a,
	output logic [`CAN_ID_B_BITS-1:0] id_b,
	output logic [`CAN_DATA_BITS-1:0] data
);

	// ==============================
	// Identifier
	// ==============================

	// Both id parts arrive MSB first
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			id_a <= '0;
			id_b <= '0;
		end
		else if (frame_start)
		begin
			id_a <= '0;
			id_b <= '0;  // Stays zero in base frames
		end
		else if (bit_take)
		begin
			if (state == st_id_a)
				id_a <= {id_a[`CAN_ID_A_BITS-2:0], rx_bit};
			if (state == st_id_b)
				id_b <= {id_b[`CAN_ID_B_BITS-2:0], rx_bit};
		end
	end

	// ==============================
	// Data bytes
	// ==============================

	// First byte ends up highest among the received ones
	// Short frames leave the upper bits zero
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			data <= '0;
		end
		else if (frame_start)
		begin
			data <= '0;
		end
		else if (bit_take && (state == st_data))
		begin
			data <= {data[`CAN_DATA_BITS-2:0], rx_bit};  // Last bit in LSB
		end
	end

	// Remote frames and DLC 0 never enter data, so data reads zero

endmodule

`default_nettype wire

/* source/can_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "can_rx_macros.svh"

module can_rx_top
	import can_rx_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        rx_bit,
	input  wire        sample_point,
	output logic       frame_valid,
	output logic       frame_error,
	output can_error_e error_kind,
	output logic [`CAN_ID_A_BITS-1:0] id_a,
	output logic [`CAN_ID_B_BITS-1:0] id_b,
	output logic       ide,
	output logic       rtr,
	output logic [`CAN_DLC_BITS-1:0]  dlc,
	output logic [`CAN_DATA_BITS-1:0] data
);

	logic       stuff_region;
	logic       stuff_bit;
	logic       stuff_error;
	logic       bit_take;     // Sample minus stuff bits
	logic       frame_start;
	logic       crc_match;
	can_state_e state;

	// Decode
	can_bit_destuffer u_destuffer (
		.clock(clock), .reset(reset), .rx_bit(rx_bit), .sample_point(sample_point),
		.stuff_region(stuff_region), .stuff_bit(stuff_bit), .stuff_error(stuff_error)
	);

	can_frame_decoder u_decoder (
		.clock(clock), .reset(reset), .rx_bit(rx_bit), .sample_point(sample_point),
		.stuff_bit(stuff_bit), .stuff_error(stuff_error), .crc_match(crc_match),
		.stuff_region(stuff_region), .bit_take(bit_take), .frame_start(frame_start),
		.state(state), .ide(ide), .rtr(rtr), .dlc(dlc),
		.frame_valid(frame_valid), .frame_error(frame_error), .error_kind(error_kind)
	);

	// Execute
	can_crc_check u_crc (
		.clock(clock), .reset(reset), .rx_bit(rx_bit), .bit_take(bit_take),
		.state(state), .frame_start(frame_start), .crc_match(crc_match)
	);

	// Result
	can_field_capture u_capture (
		.clock(clock), .reset(reset), .rx_bit(rx_bit), .bit_take(bit_take),
		.state(state), .frame_start(frame_start), .id_a(id_a), .id_b(id_b), .data(data)
	);

endmodule

`default_nettype wire

/* tb/can_rx_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module can_rx_assert
	import can_rx_pkg::*;
(
	input wire        clock,
	input wire        reset,
	input wire        sample_point,
	input can_state_e state,
	input wire        frame_valid,
	input wire        frame_error,
	input can_error_e error_kind
);

	int assert_errors = 0;  // Failure count for the final report

	// ==============================
	// Result pulses
	// ==============================
	pulses_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(frame_valid && frame_error))
	else
	begin
		assert_errors++;
		$error("frame_valid and frame_error high in the same cycle");
	end

	kind_only_with_error: assert property (@(posedge clock) disable iff (reset)
		!frame_error |-> (error_kind == err_none))
	else
	begin
		assert_errors++;
		$error("error_kind not none while frame_error is low");
	end

	// FSM moves only on a sample edge
	state_on_sample: assert property (@(posedge clock) disable iff (reset)
		!sample_point |=> $stable(state))
	else
	begin
		assert_errors++;
		$error("state changed on an edge without sample_point");
	end

endmodule

bind can_frame_decoder can_rx_assert u_assert (
	.clock(clock), .reset(reset), .sample_point(sample_point), .state(state),
	.frame_valid(frame_valid), .frame_error(frame_error), .error_kind(error_kind)
);

`default_nettype wire

/* tb/can_rx_frame_gen.svh */
`ifndef CAN_RX_FRAME_GEN_SVH
`define CAN_RX_FRAME_GEN_SVH

// ==============================
// Random source and frame buffers
// ==============================
localparam int fault_none      = 0;
localparam int fault_stuff     = 1;  // Dominant-run stuff bit made dominant
localparam int fault_crc       = 2;  // One CRC bit flipped before stuffing
localparam int fault_ack       = 3;  // Recessive ACK slot
localparam int fault_crc_delim = 4;
localparam int fault_ack_delim = 5;

int unsigned lcg_state = 69;
logic        raw_bits[$];   // SOF through CRC, unstuffed
logic        tx_bits[$];    // Bus bits as driven
int          dom_stuff[$];  // tx_bits index of stuff bits after 00000

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state >> 8;  // Low bits cycle too fast
endfunction

// MSB first, like every CAN field
function automatic void push_field(input logic [63:0] value, input int width);
	for (int i = width - 1; i >= 0; i--)
		raw_bits.push_back(value[i]);
endfunction

// Textbook CRC-15 over SOF..data
function automatic logic [`CAN_CRC_BITS-1:0] ref_crc();
	logic [`CAN_CRC_BITS-1:0] crc;
	logic                     nxt;
	crc = '0;
	foreach (raw_bits[i])
	begin
		nxt = raw_bits[i] ^ crc[`CAN_CRC_BITS-1];
		crc = {crc[`CAN_CRC_BITS-2:0], 1'b0};
		if (nxt)
			crc = crc ^ `CAN_CRC_POLY;
	end
	return crc;
endfunction

// Complement after five equal bits, stuff bit opens the next run
function automatic void stuff_frame();
	int   run;
	logic last;
	run  = 0;
	last = 1'b1;
	foreach (raw_bits[i])
	begin
		tx_bits.push_back(raw_bits[i]);
		if (raw_bits[i] == last)
			run++;
		else
		begin
			run  = 1;
			last = raw_bits[i];
		end
		if (run == `CAN_STUFF_RUN)
		begin
			if (!last)
				dom_stuff.push_back(tx_bits.size());
			tx_bits.push_back(~last);
			last = ~last;
			run  = 1;
		end
	end
endfunction

`endif

/* tb/can_rx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "can_rx_macros.svh"

module can_rx_tb
	import can_rx_pkg::*;
();

	localparam int frame_total = 60;
	localparam int wait_limit  = 400;  // Clocks after the last bit

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic frame_valid;
	logic frame_error;
	can_error_e error_kind;
	logic [`CAN_ID_A_BITS-1:0] id_a;
	logic [`CAN_ID_B_BITS-1:0] id_b;
	logic ide;
	logic rtr;
	logic [`CAN_DLC_BITS-1:0]  dlc;
	logic [`CAN_DATA_BITS-1:0] data;

	`include "can_rx_frame_gen.svh"

	// Model of the frame on the bus
	logic                      exp_valid;
	can_error_e                exp_kind;
	logic [`CAN_ID_A_BITS-1:0] exp_id_a;
	logic [`CAN_ID_B_BITS-1:0] exp_id_b;
	logic                      exp_ide;
	logic                      exp_rtr;
	logic [`CAN_DLC_BITS-1:0]  exp_dlc;
	logic [`CAN_DATA_BITS-1:0] exp_data;

	// What the monitor saw
	int                        frame_events;
	logic                      got_valid;
	can_error_e                got_kind;
	logic [`CAN_ID_A_BITS-1:0] got_id_a;
	logic [`CAN_ID_B_BITS-1:0] got_id_b;
	logic                      got_ide;
	logic                      got_rtr;
	logic [`CAN_DLC_BITS-1:0]  got_dlc;
	logic [`CAN_DATA_BITS-1:0] got_data;

	int frame_num;
	int mismatches = 0;
	int timeouts   = 0;
	int total;

	can_rx_top uut (
		.clock(clock), .reset(reset), .rx_bit(rx_bit), .sample_point(sample_point),
		.frame_valid(frame_valid), .frame_error(frame_error), .error_kind(error_kind),
		.id_a(id_a), .id_b(id_b), .ide(ide), .rtr(rtr), .dlc(dlc), .data(data)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// ==============================
	// Frame builder and model
	// ==============================
	function automatic void build_frame();
		logic                      ext;
		logic                      rtr_tx;
		logic [`CAN_DLC_BITS-1:0]  dlc_tx;
		logic [`CAN_DATA_BITS-1:0] payload;
		logic [`CAN_CRC_BITS-1:0]  crc;
		int nbytes;
		int fault;
		int gap;
		raw_bits.delete();
		tx_bits.delete();
		dom_stuff.delete();
		ext      = lcg_next() % 2;
		exp_id_a = `CAN_ID_A_BITS'(lcg_next());
		exp_id_b = ext ? `CAN_ID_B_BITS'(lcg_next()) : '0;
		rtr_tx   = (lcg_next() % 4) == 0;
		dlc_tx   = `CAN_DLC_BITS'(lcg_next());
		nbytes   = rtr_tx ? 0 : ((dlc_tx > `CAN_MAX_DATA_BYTES) ? `CAN_MAX_DATA_BYTES : dlc_tx);
		payload  = '0;
		for (int k = 0; k < nbytes; k++)
			payload = {payload[`CAN_DATA_BITS-9:0], 8'(lcg_next())};
		fault = lcg_next() % 10;
		fault = (fault < 5) ? fault_none : fault - 4;
		raw_bits.push_back(1'b0);                     // SOF
		push_field(exp_id_a, `CAN_ID_A_BITS);
		if (ext)
		begin
			raw_bits.push_back(1'b1);                 // SRR
			raw_bits.push_back(1'b1);                 // IDE
			push_field(exp_id_b, `CAN_ID_B_BITS);
			raw_bits.push_back(rtr_tx);
			raw_bits.push_back(1'b0);                 // r1
		end
		else
		begin
			raw_bits.push_back(rtr_tx);
			raw_bits.push_back(1'b0);                 // IDE
		end
		raw_bits.push_back(1'b0);                     // r0
		push_field(dlc_tx, `CAN_DLC_BITS);
		push_field(payload, nbytes * 8);
		crc = ref_crc();
		if (fault == fault_crc)
			crc[lcg_next() % `CAN_CRC_BITS] ^= 1'b1;
		push_field(crc, `CAN_CRC_BITS);
		stuff_frame();
		if (fault == fault_stuff)
		begin
			if (dom_stuff.size() > 0)
				tx_bits[dom_stuff[lcg_next() % dom_stuff.size()]] = 1'b0;
			else
				fault = fault_none;                   // Nothing to break
		end
		tx_bits.push_back(fault != fault_crc_delim);
		tx_bits.push_back(fault == fault_ack);        // ACK slot
		tx_bits.push_back(fault != fault_ack_delim);
		repeat (`CAN_EOF_BITS + `CAN_INTERMISSION_BITS) tx_bits.push_back(1'b1);
		gap = (fault != fault_none) ? 10 : ((lcg_next() % 2) ? 0 : 4);  // 0 is back-to-back
		repeat (gap) tx_bits.push_back(1'b1);
		exp_valid = (fault == fault_none);
		exp_ide   = ext;
		exp_rtr   = rtr_tx;
		exp_dlc   = (dlc_tx > `CAN_MAX_DATA_BYTES) ?
			`CAN_DLC_BITS'(`CAN_MAX_DATA_BYTES) : dlc_tx;
		exp_data  = payload;
		case (fault)
			fault_stuff:     exp_kind = err_stuff;
			fault_crc:       exp_kind = err_crc;
			fault_ack:       exp_kind = err_ack;
			fault_crc_delim: exp_kind = err_form;
			fault_ack_delim: exp_kind = err_form;
			default:         exp_kind = err_none;
		endcase
	endfunction

	// ==============================
	// Bus driver and monitor
	// ==============================
	task automatic send_bit(input logic value);
		@(posedge clock);
		rx_bit       <= value;
		sample_point <= 1'b1;
		@(posedge clock);
		sample_point <= 1'b0;
		repeat (2) @(posedge clock);  // One strobe every 4 clocks
	endtask

	always @(posedge clock)
	begin
		if (frame_valid || frame_error)
		begin
			frame_events++;
			got_valid = frame_valid;
			got_kind  = error_kind;
			got_id_a  = id_a;
			got_id_b  = id_b;
			got_ide   = ide;
			got_rtr   = rtr;
			got_dlc   = dlc;
			got_data  = data;
		end
	end

	task automatic wait_for_result();
		int cycles;
		cycles = 0;
		while ((frame_events == 0) && (cycles < wait_limit))
		begin
			@(negedge clock);
			cycles++;
		end
		if (frame_events == 0)
		begin
			$display("Timeout at %0t ns: frame %0d gave neither frame_valid nor frame_error",
				$time, frame_num);
			timeouts++;
		end
	endtask

	// ==============================
	// Checks
	// ==============================
	task automatic note_mismatch(input string msg);
		$display("MISMATCH at %0t ns: frame %0d %s", $time, frame_num, msg);
		mismatches++;
	endtask

	task automatic compare_frame(
		input logic [`CAN_ID_A_BITS-1:0] id_a_got,
		input logic [`CAN_ID_B_BITS-1:0] id_b_got,
		input logic                      ide_got,
		input logic                      rtr_got,
		input logic [`CAN_DLC_BITS-1:0]  dlc_got,
		input logic [`CAN_DATA_BITS-1:0] data_got
	);
		if (id_a_got !== exp_id_a)
			note_mismatch($sformatf("id_a got %h expected %h", id_a_got, exp_id_a));
		if (id_b_got !== exp_id_b)
			note_mismatch($sformatf("id_b got %h expected %h", id_b_got, exp_id_b));
		if (ide_got !== exp_ide)
			note_mismatch($sformatf("ide got %b expected %b", ide_got, exp_ide));
		if (rtr_got !== exp_rtr)
			note_mismatch($sformatf("rtr got %b expected %b", rtr_got, exp_rtr));
		if (dlc_got !== exp_dlc)
			note_mismatch($sformatf("dlc got %0d expected %0d", dlc_got, exp_dlc));
		if (data_got !== exp_data)
			note_mismatch($sformatf("data got %h expected %h", data_got, exp_data));
	endtask

	task automatic compare_error(input can_error_e kind_got);
		if (kind_got !== exp_kind)
			note_mismatch($sformatf("error_kind got %s expected %s",
				kind_got.name(), exp_kind.name()));
	endtask

	task automatic check_result();
		if (frame_events > 1)
			note_mismatch($sformatf("gave %0d result pulses instead of one", frame_events));
		else if (frame_events == 1)
		begin
			if (exp_valid && !got_valid)
				note_mismatch($sformatf("frame_error %s on a good frame", got_kind.name()));
			else if (!exp_valid && got_valid)
				note_mismatch($sformatf("frame_valid where %s expected", exp_kind.name()));
			else if (exp_valid)
				compare_frame(got_id_a, got_id_b, got_ide, got_rtr, got_dlc, got_data);
			else
				compare_error(got_kind);
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial
	begin
		reset        = 1'b1;
		rx_bit       = 1'b1;
		sample_point = 1'b0;
		frame_events = 0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		exp_kind = err_none;
		compare_error(error_kind);
		if (frame_valid !== 1'b0 || frame_error !== 1'b0)
			note_mismatch("result pulse high right after reset");
		repeat (12) send_bit(1'b1);                   // Idle bus
		for (frame_num = 0; frame_num < frame_total; frame_num++)
		begin
			build_frame();
			frame_events = 0;
			foreach (tx_bits[i])
				send_bit(tx_bits[i]);
			wait_for_result();
			check_result();
		end
		frame_events = 0;
		repeat (20) send_bit(1'b1);
		if (frame_events != 0)
			note_mismatch("result pulse on an idle bus");
		total = mismatches + timeouts + uut.u_decoder.u_assert.assert_errors;
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, uut.u_decoder.u_assert.assert_errors);
		if (total == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
+incdir+tb
source/can_rx_pkg.sv
source/can_bit_destuffer.sv
source/can_crc_check.sv
source/can_frame_decoder.sv
source/can_field_capture.sv
source/can_rx_top.sv
tb/can_rx_assert.sv
tb/can_rx_tb.sv

/* Bender.yml */
package:
  name: can_rx

export_include_dirs:
  - source

sources:
  - files:
      - source/can_rx_pkg.sv
      - source/can_bit_destuffer.sv
      - source/can_crc_check.sv
      - source/can_frame_decoder.sv
      - source/can_field_capture.sv
      - source/can_rx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/can_rx_assert.sv
      - tb/can_rx_tb.sv
